// ==== filelist.f ====
verilog/sec_pkg.sv
verilog/mem_msg_pkg.sv
verilog/mem_latency_timer.sv
verilog/tagged_mem.sv
verilog/proc_resp_acc.sv
verilog/mem_req_ctrl.sv
verilog/mcore_mem_acc_top.sv
dv/mem_acc_tb.sv

// ==== Makefile ====
SIM  := obj_dir/Vmem_acc_tb
SRCS := $(shell cat filelist.f)

.PHONY: all run clean

all: $(SIM)

$(SIM): filelist.f $(SRCS)
	verilator --binary --assert --timing --timescale 1ns/1ps -Wno-fatal \
		--top-module mem_acc_tb -f filelist.f -o Vmem_acc_tb

run: $(SIM)
	$(SIM) | tee sim.log
	grep -qx "sim passed" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== dv/mem_acc_tb.sv ====
// ==============================
// memory access path testbench
// directed and random requests, assertions check against a model
// ==============================

`default_nettype none

module mem_acc_tb;

	timeunit 1ns;
	timeprecision 100ps;

	import sec_pkg::*;
	import mem_msg_pkg::*;

	localparam int RESET_CYCLES = 8;
	localparam int N_DIRECTED   = 9;
	localparam int N_REQ        = N_DIRECTED + 40;
	// longest run of resp_rdy low
	localparam int MAX_STALL    = 3;
	// accept to accept is 5 + stall + 2 cycles, a little slack after reset
	localparam int TIMEOUT      = N_REQ * (5 + MAX_STALL + 2) + RESET_CYCLES + 4;

	logic       clk;
	logic       rst_n;
	logic       req_val;
	logic       req_rdy;
	mem_req_t   req_msg;
	sec_level_t proc_sec_level;
	logic       resp_val;
	logic       resp_rdy;
	mem_resp_t  resp_msg;
	logic       resp_fail;

	integer seed = 32'h959dd7d9;

	// request list with the level each one is sent at
	mem_req_t   req_list [N_REQ];
	sec_level_t lvl_list [N_REQ];

	// ==============================
	// reference model state
	// ==============================

	data_t      model_data [MEM_WORDS];
	sec_level_t model_tag  [MEM_WORDS];
	mem_resp_t  exp_msg;
	logic       exp_fail;
	// one request in flight, edges counted since its acceptance
	logic       busy;
	logic [3:0] since_acc;
	int         n_acc;
	int         n_resp;
	int         cycle_cnt = 0;
	int         stall_cnt = 0;

	mcore_mem_acc_top i_dut (
		.clk            (clk),
		.rst_n          (rst_n),
		.req_val        (req_val),
		.req_rdy        (req_rdy),
		.req_msg        (req_msg),
		.proc_sec_level (proc_sec_level),
		.resp_val       (resp_val),
		.resp_rdy       (resp_rdy),
		.resp_msg       (resp_msg),
		.resp_fail      (resp_fail)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// ==============================
	// helpers
	// ==============================

	task automatic report_value(input string name, input logic [40:0] exp,
			input logic [40:0] act);
		$display("FAIL at %0t ns: %s expected %h got %h", $time, name, exp, act);
		$display("sim failed");
		$fatal(1, "value mismatch");
	endtask

	task automatic report_error(input string what);
		$display("error at %0t ns: %s", $time, what);
		$display("sim failed");
		$fatal(1, "simulation stopped");
	endtask

	function automatic mem_req_t make_req(input mem_type_t mtype, input int opq,
			input addr_t addr, input data_t data);
		mem_req_t r;
		r.mtype  = mtype;
		r.opaque = opaque_t'(opq);
		r.addr   = addr;
		r.data   = data;
		return r;
	endfunction

	// directed cases first, then random traffic
	task automatic build_requests();
		// same level write then read
		req_list[0] = make_req(MEM_WRITE, 0, 32'h1, 32'ha1a1_0001);
		lvl_list[0] = SEC_NORMAL;
		req_list[1] = make_req(MEM_READ, 1, 32'h1, 32'h0);
		lvl_list[1] = SEC_NORMAL;
		// secure word, scrubbed for normal, visible for secure
		req_list[2] = make_req(MEM_WRITE, 2, 32'h2, 32'hb2b2_0002);
		lvl_list[2] = SEC_SECURE;
		req_list[3] = make_req(MEM_READ, 3, 32'h2, 32'h0);
		lvl_list[3] = SEC_NORMAL;
		req_list[4] = make_req(MEM_READ, 4, 32'h2, 32'h0);
		lvl_list[4] = SEC_SECURE;
		// normal word readable at secure level
		req_list[5] = make_req(MEM_READ, 5, 32'h1, 32'h0);
		lvl_list[5] = SEC_SECURE;
		// normal write retags the secure word
		req_list[6] = make_req(MEM_WRITE, 6, 32'h2, 32'hc3c3_0003);
		lvl_list[6] = SEC_NORMAL;
		req_list[7] = make_req(MEM_READ, 7, 32'h2, 32'h0);
		lvl_list[7] = SEC_NORMAL;
		// upper address bits do not select a word
		req_list[8] = make_req(MEM_READ, 8, 32'hffff_fff1, 32'h0);
		lvl_list[8] = SEC_NORMAL;
		for (int i = N_DIRECTED; i < N_REQ; i++) begin
			req_list[i] = make_req(($random(seed) & 1) ? MEM_WRITE : MEM_READ, i,
				$random(seed), $random(seed));
			lvl_list[i] = sec_level_t'($random(seed) & 1);
		end
	endtask

	// hold val and msg until the DUT takes them
	task automatic send_request(input mem_req_t msg, input sec_level_t lvl);
		req_val        = 1'b1;
		req_msg        = msg;
		proc_sec_level = lvl;
		while (!req_rdy) begin
			@(posedge clk);
			#1;
		end
		@(posedge clk);
		#1;
		req_val = 1'b0;
	endtask

	// ==============================
	// reference model
	// ==============================

	always @(posedge clk) begin : model_update
		logic [MEM_ADDR_NBITS-1:0] idx;
		if (!rst_n) begin
			busy      <= 1'b0;
			since_acc <= '0;
			n_acc     <= 0;
			n_resp    <= 0;
			for (int i = 0; i < MEM_WORDS; i++) begin
				model_data[i] <= '0;
				model_tag[i]  <= SEC_NORMAL;
			end
		end else begin
			idx = req_msg.addr[MEM_ADDR_NBITS-1:0];
			if (req_val && req_rdy) begin
				exp_msg.mtype  <= req_msg.mtype;
				exp_msg.opaque <= req_msg.opaque;
				if (req_msg.mtype == MEM_WRITE) begin
					// word takes the writer's level, response is empty
					model_data[idx] <= req_msg.data;
					model_tag[idx]  <= proc_sec_level;
					exp_msg.data    <= '0;
					exp_fail        <= 1'b0;
				end else begin
					// tag above the requester scrubs the data
					exp_fail     <= (model_tag[idx] > proc_sec_level);
					exp_msg.data <= (model_tag[idx] > proc_sec_level) ? '0 : model_data[idx];
				end
				busy      <= 1'b1;
				since_acc <= '0;
				n_acc     <= n_acc + 1;
			end else if (busy && since_acc < 4'd15) begin
				since_acc <= since_acc + 4'd1;
			end
			if (resp_val && resp_rdy) begin
				busy   <= 1'b0;
				n_resp <= n_resp + 1;
			end
		end
	end

	// ==============================
	// checks
	// ==============================

	a_resp_msg: assert property (@(posedge clk) disable iff (!rst_n)
		resp_val |-> (resp_msg == exp_msg))
		else report_value("resp_msg", $sampled(exp_msg), $sampled(resp_msg));

	a_resp_fail: assert property (@(posedge clk) disable iff (!rst_n)
		resp_val |-> (resp_fail == exp_fail))
		else report_value("resp_fail", $sampled(exp_fail), $sampled(resp_fail));

	// response appears on the fifth edge after acceptance, not before
	a_lat_early: assert property (@(posedge clk) disable iff (!rst_n)
		(busy && since_acc < 4'd5) |-> !resp_val)
		else report_value("resp_val", 41'd0, $sampled(resp_val));

	a_lat_exact: assert property (@(posedge clk) disable iff (!rst_n)
		(busy && since_acc == 4'd5) |-> resp_val)
		else report_value("resp_val", 41'd1, $sampled(resp_val));

	a_rdy_busy: assert property (@(posedge clk) disable iff (!rst_n)
		busy |-> !req_rdy)
		else report_value("req_rdy", 41'd0, $sampled(req_rdy));

	a_rdy_back: assert property (@(posedge clk) disable iff (!rst_n)
		(resp_val && resp_rdy) |=> req_rdy)
		else report_value("req_rdy", 41'd1, $sampled(req_rdy));

	// no response without a request in flight, so none is duplicated
	a_resp_owned: assert property (@(posedge clk) disable iff (!rst_n)
		resp_val |-> busy)
		else report_error("response offered with no request in flight");

	a_resp_stable: assert property (@(posedge clk) disable iff (!rst_n)
		(resp_val && !resp_rdy) |=> (resp_val && $stable(resp_msg) && $stable(resp_fail)))
		else report_error("stalled response dropped or changed");

	// ==============================
	// stimulus
	// ==============================

	// random back-pressure, bounded run of stalls
	initial begin
		wait (rst_n === 1'b1);
		forever begin
			@(posedge clk);
			#1;
			if (stall_cnt >= MAX_STALL) begin
				resp_rdy = 1'b1;
			end else begin
				resp_rdy = (($random(seed) & 3) != 0);
			end
			stall_cnt = resp_rdy ? 0 : stall_cnt + 1;
		end
	end

	initial begin
		rst_n          = 1'b0;
		req_val        = 1'b0;
		req_msg        = '0;
		proc_sec_level = SEC_NORMAL;
		resp_rdy       = 1'b0;
		build_requests();
		repeat (RESET_CYCLES) @(posedge clk);
		#1;
		rst_n = 1'b1;
		for (int i = 0; i < N_REQ; i++) begin
			send_request(req_list[i], lvl_list[i]);
		end
		while (n_resp < N_REQ) @(posedge clk);
		// a few idle cycles to catch a stray response
		repeat (4) @(posedge clk);
		if (n_resp != N_REQ || n_acc != N_REQ) begin
			report_error("number of responses differs from number of requests");
		end else begin
			$display("sim passed");
			$finish;
		end
	end

	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= TIMEOUT) begin
			report_error("timeout, the DUT stopped accepting or answering requests");
		end
	end

endmodule

`default_nettype wire

// ==== verilog/mcore_mem_acc_top.sv ====
// ==============================
// core memory access path
// controller, latency timer, tagged memory, response filter
// ==============================

`default_nettype none

module mcore_mem_acc_top (
	input  logic                   clk,
	input  logic                   rst_n,

	// request from the processor
	input  logic                   req_val,
	output logic                   req_rdy,
	input  mem_msg_pkg::mem_req_t  req_msg,
	input  sec_pkg::sec_level_t    proc_sec_level,

	// response to the processor
	output logic                   resp_val,
	input  logic                   resp_rdy,
	output mem_msg_pkg::mem_resp_t resp_msg,
	output logic                   resp_fail
);

	import sec_pkg::*;
	import mem_msg_pkg::*;

	// ==============================
	// internal nets
	// ==============================

	// controller to timer and back
	logic       timer_start;
	logic       timer_done;

	// controller to memory
	logic       mem_en;
	logic       mem_we;
	addr_t      mem_addr;
	data_t      mem_wdata;
	sec_level_t mem_wtag;
	data_t      rd_data;
	sec_level_t rd_tag;

	// controller to filter
	logic       raw_val;
	logic       raw_rdy;
	mem_resp_t  raw_msg;
	sec_level_t raw_tag;
	sec_level_t held_level;

	// ==============================
	// blocks
	// ==============================

	mem_req_ctrl i_ctrl (
		.clk            (clk),
		.rst_n          (rst_n),
		.req_val        (req_val),
		.req_rdy        (req_rdy),
		.req_msg        (req_msg),
		.proc_sec_level (proc_sec_level),
		.timer_start    (timer_start),
		.timer_done     (timer_done),
		.mem_en         (mem_en),
		.mem_we         (mem_we),
		.mem_addr       (mem_addr),
		.mem_wdata      (mem_wdata),
		.mem_wtag       (mem_wtag),
		.rd_data        (rd_data),
		.rd_tag         (rd_tag),
		.raw_val        (raw_val),
		.resp_rdy       (raw_rdy),
		.raw_msg        (raw_msg),
		.raw_tag        (raw_tag),
		.held_level     (held_level)
	);

	mem_latency_timer i_timer (
		.clk   (clk),
		.rst_n (rst_n),
		.start (timer_start),
		.done  (timer_done)
	);

	tagged_mem i_mem (
		.clk     (clk),
		.rst_n   (rst_n),
		.en      (mem_en),
		.we      (mem_we),
		.addr    (mem_addr),
		.wdata   (mem_wdata),
		.wtag    (mem_wtag),
		.rd_data (rd_data),
		.rd_tag  (rd_tag)
	);

	// compares the word tag with the level latched at acceptance
	proc_resp_acc i_acc (
		.resp_sec_level (raw_tag),
		.proc_sec_level (held_level),
		.net_resp_val   (raw_val),
		.net_resp_rdy   (raw_rdy),
		.net_resp_msg   (raw_msg),
		.proc_resp_val  (resp_val),
		.proc_resp_rdy  (resp_rdy),
		.proc_resp_msg  (resp_msg),
		.proc_resp_fail (resp_fail)
	);

endmodule

`default_nettype wire

// ==== verilog/mem_req_ctrl.sv ====
// ==============================
// memory request controller
// serial FSM, one request in flight from accept to response
// ==============================

`default_nettype none

module mem_req_ctrl (
	input  logic                   clk,
	input  logic                   rst_n,

	// processor request side
	input  logic                   req_val,
	output logic                   req_rdy,
	input  mem_msg_pkg::mem_req_t  req_msg,
	input  sec_pkg::sec_level_t    proc_sec_level,

	// latency timer
	output logic                   timer_start,
	input  logic                   timer_done,

	// tagged memory
	output logic                   mem_en,
	output logic                   mem_we,
	output mem_msg_pkg::addr_t     mem_addr,
	output mem_msg_pkg::data_t     mem_wdata,
	output sec_pkg::sec_level_t    mem_wtag,
	input  mem_msg_pkg::data_t     rd_data,
	input  sec_pkg::sec_level_t    rd_tag,

	// raw response towards the access filter
	output logic                   raw_val,
	input  logic                   resp_rdy,
	output mem_msg_pkg::mem_resp_t raw_msg,
	output sec_pkg::sec_level_t    raw_tag,
	output sec_pkg::sec_level_t    held_level
);

	import sec_pkg::*;
	import mem_msg_pkg::*;

	typedef enum logic [1:0] {
		IDLE,
		WAIT,
		ACCESS,
		RESP
	} state_t;

	state_t     state;
	state_t     state_nxt;
	mem_req_t   req_q;
	sec_level_t level_q;
	logic       accept;
	logic       is_read;

	// handshake on the request side
	assign accept  = req_val && req_rdy;
	assign is_read = (req_q.mtype == MEM_READ);

	// ==============================
	// state machine
	// ==============================

	always_comb begin
		state_nxt = state;
		case (state)
			IDLE:    if (req_val) state_nxt = WAIT;
			WAIT:    if (timer_done) state_nxt = ACCESS;
			// memory output is valid in this state
			ACCESS:  state_nxt = RESP;
			// leave as soon as the response is taken
			RESP:    if (resp_rdy) state_nxt = IDLE;
			default: state_nxt = IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state       <= IDLE;
			timer_start <= 1'b0;
		end else begin
			state       <= state_nxt;
			// one cycle pulse right after acceptance
			timer_start <= accept;
		end
	end

	// ==============================
	// request and response registers
	// ==============================

	always_ff @(posedge clk) begin
		// requester level is sampled together with the request
		if (accept) begin
			req_q   <= req_msg;
			level_q <= proc_sec_level;
		end
		// build the raw response from the memory output
		if (state == ACCESS) begin
			raw_msg.mtype  <= req_q.mtype;
			raw_msg.opaque <= req_q.opaque;
			raw_msg.data   <= is_read ? rd_data : '0;
			// writes report a normal tag so they never fail
			raw_tag        <= is_read ? rd_tag : SEC_NORMAL;
		end
	end

	// ==============================
	// outputs
	// ==============================

	assign req_rdy    = (state == IDLE);
	assign raw_val    = (state == RESP);
	assign held_level = level_q;

	// access fires on the cycle the timer expires
	assign mem_en    = (state == WAIT) && timer_done;
	assign mem_we    = !is_read;
	assign mem_addr  = req_q.addr;
	assign mem_wdata = req_q.data;
	// written word takes the level of its writer
	assign mem_wtag  = level_q;

	// access ends the wait, one full timer run after the start pulse
	a_mem_en_leaves_wait: assert property (@(posedge clk) disable iff (!rst_n)
		mem_en |-> $past(timer_start, MEM_LAT_CYCLES));

	// a stalled response must not change under the consumer
	a_raw_stable: assert property (@(posedge clk) disable iff (!rst_n)
		(raw_val && !resp_rdy) |=> (raw_val && $stable(raw_msg) && $stable(raw_tag)));

endmodule

`default_nettype wire

// ==== verilog/proc_resp_acc.sv ====
// ==============================
// response access filter
// scrubs read data tagged above the requester level
// ==============================

`default_nettype none

module proc_resp_acc (
	// levels of the stored word and of the requester
	input  sec_pkg::sec_level_t    resp_sec_level,
	input  sec_pkg::sec_level_t    proc_sec_level,

	// raw response from the controller
	input  logic                   net_resp_val,
	output logic                   net_resp_rdy,
	input  mem_msg_pkg::mem_resp_t net_resp_msg,

	// filtered response to the processor
	output logic                   proc_resp_val,
	input  logic                   proc_resp_rdy,
	output mem_msg_pkg::mem_resp_t proc_resp_msg,
	output logic                   proc_resp_fail
);

	// word is more privileged than whoever asked for it
	logic blocked;

	assign blocked = (resp_sec_level > proc_sec_level);

	always_comb begin
		// handshake goes straight through
		proc_resp_val = net_resp_val;
		net_resp_rdy  = proc_resp_rdy;
		proc_resp_msg = net_resp_msg;
		// data is scrubbed even when no response is offered
		if (blocked) begin
			proc_resp_msg.data = '0;
		end
		// fail only qualifies a valid response
		proc_resp_fail = blocked && net_resp_val;
	end

endmodule

`default_nettype wire

// ==== verilog/tagged_mem.sv ====
// ==============================
// tagged memory
// word array with one security tag per word
// ==============================

`default_nettype none

module tagged_mem (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                en,
	input  logic                we,
	input  mem_msg_pkg::addr_t  addr,
	input  mem_msg_pkg::data_t  wdata,
	input  sec_pkg::sec_level_t wtag,
	output mem_msg_pkg::data_t  rd_data,
	output sec_pkg::sec_level_t rd_tag
);

	import sec_pkg::*;
	import mem_msg_pkg::*;

	// storage, data and tags indexed alike
	data_t      words [MEM_WORDS];
	sec_level_t tags  [MEM_WORDS];

	// word index, upper address bits are ignored
	logic [MEM_ADDR_NBITS-1:0] idx;

	assign idx = addr[MEM_ADDR_NBITS-1:0];

	// ==============================
	// write port
	// ==============================

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			// every word starts as normal zero
			for (int i = 0; i < MEM_WORDS; i++) begin
				words[i] <= '0;
				tags[i]  <= SEC_NORMAL;
			end
		end else if (en && we) begin
			words[idx] <= wdata;
			// retag, no write protection
			tags[idx]  <= wtag;
		end
	end

	// ==============================
	// read port
	// ==============================

	// one cycle latency, output holds until the next read
	always_ff @(posedge clk) begin
		if (en && !we) begin
			rd_data <= words[idx];
			rd_tag  <= tags[idx];
		end
	end

endmodule

`default_nettype wire

// ==== verilog/mem_latency_timer.sv ====
// ==============================
// memory latency timer
// fixed length down-counter, pulses done at its end
// ==============================

`default_nettype none

module mem_latency_timer (
	input  logic clk,
	input  logic rst_n,
	input  logic start,
	output logic done
);

	import mem_msg_pkg::*;

	// zero means idle
	logic [MEM_LAT_NBITS-1:0] count;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			count <= '0;
		end else if (start) begin
			count <= MEM_LAT_NBITS'(MEM_LAT_CYCLES);
		end else if (count != '0) begin
			count <= count - 1'b1;
		end
	end

	// last counting cycle, count drops to zero right after
	assign done = (count == MEM_LAT_NBITS'(1));

	// controller keeps a single access in flight
	a_no_restart: assert property (@(posedge clk) disable iff (!rst_n)
		start |-> (count == '0));

endmodule

`default_nettype wire

// ==== verilog/mem_msg_pkg.sv ====
// ==============================
// memory message package
// request and response formats, memory geometry, latency
// ==============================

`default_nettype none

package mem_msg_pkg;

	// ==============================
	// field types
	// ==============================

	// message type, encoded as in the vc mem messages
	typedef enum logic {
		MEM_READ  = 1'b0,
		MEM_WRITE = 1'b1
	} mem_type_t;

	// tag the processor uses to match a response to its request
	typedef logic [7:0] opaque_t;

	// full byte address, only the low word index bits reach the array
	typedef logic [31:0] addr_t;

	// one memory word
	typedef logic [31:0] data_t;

	// ==============================
	// geometry and timing
	// ==============================

	localparam int MEM_WORDS      = 16;
	localparam int MEM_ADDR_NBITS = 4;

	// cycles the latency timer runs per access
	localparam int MEM_LAT_CYCLES = 3;
	// width of the timer count, holds 0 up to MEM_LAT_CYCLES
	localparam int MEM_LAT_NBITS  = $clog2(MEM_LAT_CYCLES + 1);

	// ==============================
	// messages
	// ==============================

	// request, 1 + 8 + 32 + 32 = 73 bits
	typedef struct packed {
		mem_type_t mtype;
		opaque_t   opaque;
		addr_t     addr;
		data_t     data;
	} mem_req_t;

	// response, 1 + 8 + 32 = 41 bits
	typedef struct packed {
		mem_type_t mtype;
		opaque_t   opaque;
		data_t     data;
	} mem_resp_t;

endpackage

`default_nettype wire

// ==== verilog/sec_pkg.sv ====
// ==============================
// security level definitions
// one bit level shared by processor and memory tags
// ==============================

`default_nettype none

package sec_pkg;

	// level of a requester or of a stored word
	// a higher value means more privileged
	typedef logic sec_level_t;

	// ordinary accesses
	localparam sec_level_t SEC_NORMAL = 1'b0;

	// secure accesses, may read everything
	localparam sec_level_t SEC_SECURE = 1'b1;

endpackage

`default_nettype wire
